//--- rtl/alu.sv
module alu (
    input  logic [cpuArchPkg::dataWidth-1:0]     yData,
    input  logic [cpuArchPkg::dataWidth-1:0]     busData,
    input  busCtrlPkg::aluOpE                    aluOp,
    output logic [2*cpuArchPkg::dataWidth-1:0]   aluResult
);
    import cpuArchPkg::*;
    import busCtrlPkg::*;

    localparam int shiftBits = $clog2(dataWidth);

    logic        [shiftBits-1:0]   shiftAmt;
    logic        [2*dataWidth-1:0] rotWord;
    logic        [2*dataWidth-1:0] rorShift;
    logic        [2*dataWidth-1:0] rolShift;
    logic signed [2*dataWidth-1:0] product;

    // Shift count from the low bus bits
    assign shiftAmt = busData[shiftBits-1:0];

    // Rotates shift a doubled copy of Y
    assign rotWord  = {yData, yData};
    assign rorShift = rotWord >> shiftAmt;
    assign rolShift = rotWord << shiftAmt;

    assign product = $signed(yData) * $signed(busData);

    always_comb begin
        aluResult = '0;
        case (aluOp)
            aluAdd: begin
                aluResult[dataWidth-1:0] = yData + busData;
            end
            aluSub: begin
                aluResult[dataWidth-1:0] = yData - busData;
            end
            aluAnd: begin
                aluResult[dataWidth-1:0] = yData & busData;
            end
            aluOr: begin
                aluResult[dataWidth-1:0] = yData | busData;
            end
            aluShr: begin
                aluResult[dataWidth-1:0] = yData >> shiftAmt;
            end
            aluShra: begin
                aluResult[dataWidth-1:0] = $signed(yData) >>> shiftAmt;
            end
            aluShl: begin
                aluResult[dataWidth-1:0] = yData << shiftAmt;
            end
            aluRor: begin
                aluResult[dataWidth-1:0] = rorShift[dataWidth-1:0];
            end
            aluRol: begin
                aluResult[dataWidth-1:0] = rolShift[2*dataWidth-1 -: dataWidth];
            end
            aluMul: begin
                aluResult = product; // HI gets the upper half
            end
            aluNeg: begin
                aluResult[dataWidth-1:0] = '0 - busData;
            end
            aluNot: begin
                aluResult[dataWidth-1:0] = ~busData;
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

endmodule

//--- rtl/busCtrlPkg.sv
package busCtrlPkg;

    // ALU op codes line up with the opcode of the matching instruction
    typedef enum logic [4:0] {
        aluAdd  = 5'd3,
        aluSub  = 5'd4,
        aluAnd  = 5'd5,
        aluOr   = 5'd6,
        aluShr  = 5'd7,
        aluShra = 5'd8,
        aluShl  = 5'd9,
        aluRor  = 5'd10,
        aluRol  = 5'd11,
        aluMul  = 5'd15,
        aluNeg  = 5'd16,
        aluNot  = 5'd17
    } aluOpE;

    // Bus sources, srcNone drives zero
    typedef enum logic [3:0] {
        srcGpr, srcHi, srcLo, srcZHigh, srcZLow,
        srcPc, srcMdr, srcInPort, srcCSign, srcNone
    } busSrcE;

endpackage

//--- rtl/busMux.sv
module busMux (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             regOut,
    input  logic                             baOut,
    input  logic                             hiOut,
    input  logic                             loOut,
    input  logic                             zHighOut,
    input  logic                             zLowOut,
    input  logic                             pcOut,
    input  logic                             mdrOut,
    input  logic                             inPortOut,
    input  logic                             cOut,
    input  logic [cpuArchPkg::dataWidth-1:0] gprData,
    input  logic [cpuArchPkg::dataWidth-1:0] hiData,
    input  logic [cpuArchPkg::dataWidth-1:0] loData,
    input  logic [cpuArchPkg::dataWidth-1:0] zHigh,
    input  logic [cpuArchPkg::dataWidth-1:0] zLow,
    input  logic [cpuArchPkg::dataWidth-1:0] pcData,
    input  logic [cpuArchPkg::dataWidth-1:0] mdrData,
    input  logic [cpuArchPkg::dataWidth-1:0] inPortData,
    input  logic [cpuArchPkg::dataWidth-1:0] cSign,
    output logic [cpuArchPkg::dataWidth-1:0] busData
);
    import cpuArchPkg::*;
    import busCtrlPkg::*;

    busSrcE busSrc;

    // Strobe encoder, both register read strobes pick the GPR word
    always_comb begin
        if (regOut || baOut)  busSrc = srcGpr;
        else if (hiOut)       busSrc = srcHi;
        else if (loOut)       busSrc = srcLo;
        else if (zHighOut)    busSrc = srcZHigh;
        else if (zLowOut)     busSrc = srcZLow;
        else if (pcOut)       busSrc = srcPc;
        else if (mdrOut)      busSrc = srcMdr;
        else if (inPortOut)   busSrc = srcInPort;
        else if (cOut)        busSrc = srcCSign;
        else                  busSrc = srcNone;
    end

    always_comb begin
        case (busSrc)
            srcGpr:    busData = gprData;
            srcHi:     busData = hiData;
            srcLo:     busData = loData;
            srcZHigh:  busData = zHigh;
            srcZLow:   busData = zLow;
            srcPc:     busData = pcData;
            srcMdr:    busData = mdrData;
            srcInPort: busData = inPortData;
            srcCSign:  busData = cSign;
            default:   busData = '0; // Idle bus reads zero
        endcase
    end

    // Only one driver per microstep
    strobeOneHot: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({regOut, baOut, hiOut, loOut, zHighOut, zLowOut,
                  pcOut, mdrOut, inPortOut, cOut}))
        else $error("busMux: several out strobes in one cycle");

endmodule

//--- rtl/conFf.sv
module conFf (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [cpuArchPkg::dataWidth-1:0] irData,
    input  logic [cpuArchPkg::dataWidth-1:0] busData,
    input  logic                             conIn,
    output logic                             conOut
);
    import cpuArchPkg::*;

    logic [condWidth-1:0]    cond;
    logic [2**condWidth-1:0] condSel;
    logic [2**condWidth-1:0] condTrue;
    logic                    isZero;
    logic                    isNeg;

    assign cond   = irData[condLsb +: condWidth];
    assign isZero = (busData == '0);
    assign isNeg  = busData[dataWidth-1];

    // 2-to-4 decode of the condition code
    assign condSel = (2**condWidth)'(1) << cond;

    // Codes 3..0 are negative, positive, nonzero, zero
    assign condTrue = {isNeg, !isNeg && !isZero, !isZero, isZero};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            conOut <= 1'b0;
        end else if (conIn) begin
            conOut <= |(condSel & condTrue);
        end
    end

endmodule

//--- rtl/cpuArchPkg.sv
package cpuArchPkg;

    localparam int dataWidth   = 32;
    localparam int regCount    = 16;
    localparam int regSelWidth = $clog2(regCount);

    // Instruction word layout, low bit of each field
    localparam int opcodeLsb  = 27;    // 31..27
    localparam int raLsb      = 23;    // 26..23
    localparam int rbLsb      = 19;    // 22..19
    localparam int rcLsb      = 15;    // 18..15
    localparam int constLsb   = 0;
    localparam int constWidth = 19;    // 18..0, sign at bit 18
    localparam int condLsb    = rbLsb; // Branch condition sits in the low bits of rb
    localparam int condWidth  = 2;

    typedef enum logic [4:0] {
        opLd, opLdi, opSt, opAdd, opSub, opAnd, opOr, opShr, opShra,
        opShl, opRor, opRol, opAddi, opAndi, opOri, opMul, opNeg, opNot,
        opBrx, opIn, opOut, opMfhi, opMflo, opNop, opHalt
    } opcodeE;

endpackage

//--- rtl/datapath.sv
module datapath #(
    parameter int memDepth = 512,
    parameter int pcStep   = 1
) (
    input  logic                             clk,
    input  logic                             rstN,
    // Out strobes
    input  logic                             regOut,
    input  logic                             baOut,
    input  logic                             hiOut,
    input  logic                             loOut,
    input  logic                             zHighOut,
    input  logic                             zLowOut,
    input  logic                             pcOut,
    input  logic                             mdrOut,
    input  logic                             inPortOut,
    input  logic                             cOut,
    // In strobes
    input  logic                             pcIn,
    input  logic                             irIn,
    input  logic                             yIn,
    input  logic                             zIn,
    input  logic                             hiIn,
    input  logic                             loIn,
    input  logic                             marIn,
    input  logic                             mdrIn,
    input  logic                             outPortIn,
    input  logic                             incPc,
    input  logic                             regIn,
    input  logic                             conIn,
    input  logic                             memRead,
    input  logic                             memWrite,
    // IR field selects
    input  logic                             gra,
    input  logic                             grb,
    input  logic                             grc,
    input  busCtrlPkg::aluOpE                aluOp,
    input  logic [cpuArchPkg::dataWidth-1:0] inPortIn,
    output logic [cpuArchPkg::dataWidth-1:0] busData,
    output logic [cpuArchPkg::dataWidth-1:0] outPortData,
    output logic                             conOut
);
    import cpuArchPkg::*;

    logic [regCount-1:0]    regRead;
    logic [regCount-1:0]    regWrite;
    logic [dataWidth-1:0]   gprData;
    logic [dataWidth-1:0]   hiData;
    logic [dataWidth-1:0]   loData;
    logic [dataWidth-1:0]   zHigh;
    logic [dataWidth-1:0]   zLow;
    logic [dataWidth-1:0]   pcData;
    logic [dataWidth-1:0]   irData;
    logic [dataWidth-1:0]   yData;
    logic [dataWidth-1:0]   mdrData;
    logic [dataWidth-1:0]   inPortData;
    logic [dataWidth-1:0]   cSign;
    logic [2*dataWidth-1:0] aluResult;

    // Port names match the nets one to one
    selectEncode selEnc (.*);
    registerFile regFile (.*);
    alu          aluCore (.*);
    conFf        conLogic (.*);
    busMux       busSel (.*);

    memoryUnit #(
        .memDepth(memDepth)
    ) memory (.*);

    specialRegs #(
        .pcStep(pcStep)
    ) specRegs (.*);

endmodule

//--- rtl/memoryUnit.sv
module memoryUnit #(
    parameter int memDepth = 512
) (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [cpuArchPkg::dataWidth-1:0] busData,
    input  logic                             marIn,
    input  logic                             mdrIn,
    input  logic                             memRead,
    input  logic                             memWrite,
    output logic [cpuArchPkg::dataWidth-1:0] mdrData
);
    import cpuArchPkg::*;

    localparam int addrWidth = $clog2(memDepth);

    logic [dataWidth-1:0] ram [memDepth];
    logic [addrWidth-1:0] marAddr;

    // MAR keeps only the address bits the RAM decodes
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            marAddr <= '0;
            mdrData <= '0;
        end else begin
            if (marIn) begin
                marAddr <= busData[addrWidth-1:0];
            end
            if (mdrIn) begin
                mdrData <= memRead ? ram[marAddr] : busData; // RAM word or bus
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memWrite) begin
            ram[marAddr] <= mdrData;
        end
    end

    // A RAM read only lands somewhere when MDR loads
    readIntoMdr: assert property (@(posedge clk) disable iff (!rstN) memRead |-> mdrIn)
        else $error("memoryUnit: memRead without mdrIn");

endmodule

//--- rtl/registerFile.sv
module registerFile (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [cpuArchPkg::dataWidth-1:0] busData,
    input  logic [cpuArchPkg::regCount-1:0]  regRead,
    input  logic [cpuArchPkg::regCount-1:0]  regWrite,
    input  logic                             baOut,
    output logic [cpuArchPkg::dataWidth-1:0] gprData
);
    import cpuArchPkg::*;

    logic [dataWidth-1:0] regs [regCount];
    logic [regCount-1:0]  readSel;

    // Base addressing: R0 drops out and reads as zero
    assign readSel = baOut ? {regRead[regCount-1:1], 1'b0} : regRead;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < regCount; i++) begin
                if (regWrite[i]) begin
                    regs[i] <= busData;
                end
            end
        end
    end

    // Select is one-hot, an OR of the gated words is enough
    always_comb begin
        gprData = '0;
        for (int i = 0; i < regCount; i++) begin
            if (readSel[i]) begin
                gprData = gprData | regs[i];
            end
        end
    end

    // Write enables come from the IR decode in selectEncode
    writeOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(regWrite))
        else $error("registerFile: several write enables in one cycle");

endmodule

//--- rtl/selectEncode.sv
module selectEncode (
    input  logic [cpuArchPkg::dataWidth-1:0] irData,
    input  logic                             gra,
    input  logic                             grb,
    input  logic                             grc,
    input  logic                             regIn,
    input  logic                             regOut,
    input  logic                             baOut,
    output logic [cpuArchPkg::regCount-1:0]  regRead,
    output logic [cpuArchPkg::regCount-1:0]  regWrite,
    output logic [cpuArchPkg::dataWidth-1:0] cSign
);
    import cpuArchPkg::*;

    logic [regSelWidth-1:0] regIndex;
    logic [regCount-1:0]    regDecode;
    logic                   anySel;

    // The opcode field above ra has to hold every opcode
    if ($bits(opcodeE) != dataWidth - opcodeLsb) begin : gOpcodeCheck
        $error("selectEncode: opcode field does not fit opcodeE");
    end

    assign anySel = gra | grb | grc;

    // Field select as an AND-OR of the three IR fields
    assign regIndex = ({regSelWidth{gra}} & irData[raLsb +: regSelWidth])
                    | ({regSelWidth{grb}} & irData[rbLsb +: regSelWidth])
                    | ({regSelWidth{grc}} & irData[rcLsb +: regSelWidth]);

    always_comb begin
        regDecode = '0;
        regDecode[regIndex] = anySel; // Nothing selected without a field strobe
    end

    assign regWrite = regDecode & {regCount{regIn}};
    assign regRead  = regDecode & {regCount{regOut | baOut}};

    // 19-bit constant, sign-extended for the C out path
    assign cSign = {{(dataWidth - constWidth){irData[constLsb + constWidth - 1]}},
                    irData[constLsb +: constWidth]};

endmodule

//--- rtl/specialRegs.sv
module specialRegs #(
    parameter int pcStep = 1
) (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic [cpuArchPkg::dataWidth-1:0]   busData,
    input  logic [2*cpuArchPkg::dataWidth-1:0] aluResult,
    input  logic                               pcIn,
    input  logic                               irIn,
    input  logic                               yIn,
    input  logic                               zIn,
    input  logic                               incPc,
    input  logic                               hiIn,
    input  logic                               loIn,
    input  logic                               outPortIn,
    input  logic [cpuArchPkg::dataWidth-1:0]   inPortIn,
    output logic [cpuArchPkg::dataWidth-1:0]   pcData,
    output logic [cpuArchPkg::dataWidth-1:0]   irData,
    output logic [cpuArchPkg::dataWidth-1:0]   yData,
    output logic [cpuArchPkg::dataWidth-1:0]   zHigh,
    output logic [cpuArchPkg::dataWidth-1:0]   zLow,
    output logic [cpuArchPkg::dataWidth-1:0]   hiData,
    output logic [cpuArchPkg::dataWidth-1:0]   loData,
    output logic [cpuArchPkg::dataWidth-1:0]   inPortData,
    output logic [cpuArchPkg::dataWidth-1:0]   outPortData
);
    import cpuArchPkg::*;

    logic [dataWidth-1:0] pcNext;

    assign pcNext = pcData + dataWidth'(pcStep);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcData      <= '0;
            irData      <= '0;
            yData       <= '0;
            zHigh       <= '0;
            zLow        <= '0;
            hiData      <= '0;
            loData      <= '0;
            inPortData  <= '0;
            outPortData <= '0;
        end else begin
            if (pcIn)      pcData      <= busData;
            if (irIn)      irData      <= busData;
            if (yIn)       yData       <= busData;
            if (hiIn)      hiData      <= busData;
            if (loIn)      loData      <= busData;
            if (outPortIn) outPortData <= busData;
            // PC increment shares the Z path with the ALU
            if (zIn || incPc) begin
                {zHigh, zLow} <= incPc ? {{dataWidth{1'b0}}, pcNext} : aluResult;
            end
            inPortData <= inPortIn; // Free-running sample of the pins
        end
    end

endmodule

//--- runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module datapathTb -o simDatapath
./obj_dir/simDatapath > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
grep -q "SIMULATION PASSED" sim.log

//--- verification/datapathGolden.txt
# out: regOut baOut hiOut loOut zHighOut zLowOut pcOut mdrOut inPortOut cOut
# in: pcIn irIn yIn zIn hiIn loIn marIn mdrIn outPortIn incPc regIn conIn memRead memWrite
# sel: gra grb grc | aluOp | inPortIn | bus | outPortData | conOut | mask: bus out con
0000000000 00000000000000 000 03 08080045 00000000 00000000 0 110
0000000010 00000001000000 000 03 00800000 08080045 00000000 0 100
0000000010 01000000000001 000 03 00002F54 00800000 00000000 0 100
0000000010 00000000001000 100 03 00000000 00002F54 00000000 0 100
0000001000 00000010010000 000 03 00000000 00000000 00000000 0 100
0000010000 10000001000010 000 03 00000000 00000001 00000000 0 100
0000000100 01000000000000 000 03 00000000 08080045 00000000 0 100
0100000000 00100000000000 010 03 00000000 00002F54 00000000 0 100
0000000001 00010000000000 000 03 00000000 00000045 00000000 0 100
0000010000 00000000001000 100 03 00000000 00002F99 00000000 0 100
1000000000 00000000000000 100 03 00000000 00002F99 00000000 0 100
0100000000 00000000000000 100 03 00000000 00000000 00000000 0 100
1000000000 00100000000000 100 03 00000000 00002F99 00000000 0 100
1000000000 00010000000000 010 03 00000000 00002F54 00000000 0 100
0000010000 00000000000000 000 03 00000000 00005EED 00000000 0 100
1000000000 00010000000000 010 04 00000000 00002F54 00000000 0 100
0000010000 00000000000000 000 04 00000000 00000045 00000000 0 100
1000000000 00010000000000 010 05 00000000 00002F54 00000000 0 100
0000010000 00000000000000 000 05 00000000 00002F10 00000000 0 100
1000000000 00010000000000 010 06 00000000 00002F54 00000000 0 100
0000010000 00000000000000 000 06 80002F99 00002FDD 00000000 0 100
0000000010 00100000000000 000 03 00000000 80002F99 00000000 0 100
0000000001 00010000000000 000 07 00000000 00000045 00000000 0 100
0000010000 00000000000000 000 07 00000000 0400017C 00000000 0 100
0000000001 00010000000000 000 08 00000000 00000045 00000000 0 100
0000010000 00000000000000 000 08 00000000 FC00017C 00000000 0 100
0000000001 00010000000000 000 09 00000000 00000045 00000000 0 100
0000010000 00000000000000 000 09 00000000 0005F320 00000000 0 100
0000000001 00010000000000 000 0A 00000000 00000045 00000000 0 100
0000010000 00000000000000 000 0A 00000000 CC00017C 00000000 0 100
0000000001 00010000000000 000 0B 00000000 00000045 00000000 0 100
0000010000 00000000000000 000 0B 00000000 0005F330 00000000 0 100
0000000001 00010000000000 000 10 00000000 00000045 00000000 0 100
0000010000 00000000000000 000 10 00000000 FFFFFFBB 00000000 0 100
0000000001 00010000000000 000 11 00000000 00000045 00000000 0 100
0000010000 00000000000000 000 11 00000000 FFFFFFBA 00000000 0 100
0000000001 00010000000000 000 0F 00000000 00000045 00000000 0 100
0000100000 00001000000000 000 0F 00000000 FFFFFFDD 00000000 0 100
0000010000 00000100000000 000 0F 00000000 800CD43D 00000000 0 100
0010000000 00000000000000 000 03 00000000 FFFFFFDD 00000000 0 100
0001000000 00000000000000 000 03 00000000 800CD43D 00000000 0 100
0000000001 00000010000000 000 03 00000000 00000045 00000000 0 100
1000000000 00000001000000 100 03 00000000 00002F99 00000000 0 100
0000000000 00000000000001 000 03 00000000 00000000 00000000 0 100
0000000001 00000001000000 000 03 00000000 00000045 00000000 0 100
0000000000 00000001000010 000 03 00000000 00000000 00000000 0 100
0000000100 00000000000000 000 03 00000000 00002F99 00000000 0 100
0000000010 01000000000000 000 03 00000000 00000000 00000000 0 100
0000000010 00000000000100 000 03 00000005 00000000 00000000 1 101
0000000010 00000000000100 000 03 FFFFFFFD 00000005 00000000 0 101
0000000010 00000000000100 000 03 00080000 FFFFFFFD 00000000 0 101
0000000010 01000000000000 000 03 00000000 00080000 00000000 0 100
0000000010 00000000000100 000 03 00000005 00000000 00000000 0 101
0000000010 00000000000100 000 03 FFFFFFFD 00000005 00000000 1 101
0000000010 00000000000100 000 03 00100000 FFFFFFFD 00000000 1 101
0000000010 01000000000000 000 03 00000000 00100000 00000000 0 100
0000000010 00000000000100 000 03 00000005 00000000 00000000 0 101
0000000010 00000000000100 000 03 FFFFFFFD 00000005 00000000 1 101
0000000010 00000000000100 000 03 00180000 FFFFFFFD 00000000 0 101
0000000010 01000000000000 000 03 00000000 00180000 00000000 0 100
0000000010 00000000000100 000 03 00000005 00000000 00000000 0 101
0000000010 00000000000100 000 03 FFFFFFFD 00000005 00000000 0 101
0000000010 00000000000100 000 03 00000000 FFFFFFFD 00000000 1 101
1000000000 00000000100000 100 03 00000000 00002F99 00002F99 0 110
0000000000 00000000000000 000 03 00000000 00000000 00002F99 0 110

//--- verification/datapathTb.sv
module datapathTb;
    import cpuArchPkg::*;
    import busCtrlPkg::*;

    logic                 clk;
    logic                 rstN;
    logic                 regOut, baOut, hiOut, loOut, zHighOut;
    logic                 zLowOut, pcOut, mdrOut, inPortOut, cOut;
    logic                 pcIn, irIn, yIn, zIn, hiIn, loIn, marIn;
    logic                 mdrIn, outPortIn, incPc, regIn, conIn, memRead, memWrite;
    logic                 gra, grb, grc;
    aluOpE                aluOp;
    logic [dataWidth-1:0] inPortIn;
    logic [dataWidth-1:0] busData;
    logic [dataWidth-1:0] outPortData;
    logic                 conOut;

    // One entry per microstep of the golden file
    logic [9:0]           outQ[$];
    logic [13:0]          inQ[$];
    logic [2:0]           selQ[$];
    logic [4:0]           opQ[$];
    logic [dataWidth-1:0] portQ[$];
    logic [dataWidth-1:0] busQ[$];
    logic [dataWidth-1:0] outPortQ[$];
    logic                 conQ[$];
    logic [2:0]           maskQ[$]; // Bus, output port, CON

    int wordErrors;
    int flagErrors;
    int cycleCount;
    int cycleLimit;

    datapath #(
        .memDepth(512),
        .pcStep(1)
    ) DUT (.*);

    always #50 clk = ~clk;

    // Run limit from the vector count
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: the run passed %0d cycles without finishing", cycleLimit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic readGolden;
        int    fd;
        int    count;
        string line;
        logic [9:0]           o;
        logic [13:0]          s;
        logic [2:0]           g;
        logic [4:0]           op;
        logic [dataWidth-1:0] port, bus, outP;
        logic                 con;
        logic [2:0]           mask;
        fd = $fopen("verification/datapathGolden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                count = $sscanf(line, "%b %b %b %h %h %h %h %b %b",
                                o, s, g, op, port, bus, outP, con, mask);
                if (count == 9) begin // Comment and blank lines fall out here
                    outQ.push_back(o);
                    inQ.push_back(s);
                    selQ.push_back(g);
                    opQ.push_back(op);
                    portQ.push_back(port);
                    busQ.push_back(bus);
                    outPortQ.push_back(outP);
                    conQ.push_back(con);
                    maskQ.push_back(mask);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic applyVector(input int idx);
        {regOut, baOut, hiOut, loOut, zHighOut, zLowOut,
         pcOut, mdrOut, inPortOut, cOut} <= outQ[idx];
        {pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn,
         outPortIn, incPc, regIn, conIn, memRead, memWrite} <= inQ[idx];
        {gra, grb, grc} <= selQ[idx];
        aluOp           <= aluOpE'(opQ[idx]);
        inPortIn        <= portQ[idx];
    endtask

    task automatic checkWord(input string what, input logic [dataWidth-1:0] actual,
                             input logic [dataWidth-1:0] expected);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            wordErrors++;
        end
    endtask

    task automatic checkFlag(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s is %b, expected %b", $time, what, actual, expected);
            flagErrors++;
        end
    endtask

    // Registered results of a step show up one edge later
    task automatic checkRegistered(input int idx);
        if (maskQ[idx][1]) checkWord("outPortData", outPortData, outPortQ[idx]);
        if (maskQ[idx][0]) checkFlag("conOut", conOut, conQ[idx]);
    endtask

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        {regOut, baOut, hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut} = '0;
        {pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn} = '0;
        {outPortIn, incPc, regIn, conIn, memRead, memWrite} = '0;
        {gra, grb, grc} = '0;
        aluOp      = aluAdd;
        inPortIn   = '0;
        wordErrors = 0;
        flagErrors = 0;
        cycleCount = 0;
        cycleLimit = 0;

        readGolden();
        cycleLimit = 4 * outQ.size();

        repeat (3) @(posedge clk);
        rstN <= 1'b1;

        foreach (outQ[i]) begin
            @(posedge clk);
            applyVector(i);
            @(negedge clk);
            if (i > 0) checkRegistered(i - 1);
            if (maskQ[i][2]) checkWord("busData", busData, busQ[i]);
        end
        @(posedge clk);
        @(negedge clk);
        if (outQ.size() > 0) checkRegistered(outQ.size() - 1);

        $display("Errors: %0d word, %0d flag, over %0d steps",
                 wordErrors, flagErrors, outQ.size());
        if (wordErrors == 0 && flagErrors == 0 && outQ.size() > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/cpuArchPkg.sv
rtl/busCtrlPkg.sv
rtl/registerFile.sv
rtl/selectEncode.sv
rtl/alu.sv
rtl/conFf.sv
rtl/memoryUnit.sv
rtl/busMux.sv
rtl/specialRegs.sv
rtl/datapath.sv
verification/datapathTb.sv
